/* mips_bus_defs.svh */
`ifndef MIPS_BUS_DEFS_SVH
`define MIPS_BUS_DEFS_SVH

// data and address width of the core ports and the avalon link
`define MIPS_DATA_W 32

// ram depth in 32-bit words, address wraps modulo this
`define MIPS_MEM_WORDS 1024

// waitrequest cycles before an access completes
// access takes MIPS_MEM_WAIT+1 cycles on the bus
`define MIPS_MEM_WAIT 2

`endif

/* mips_bus_pkg.sv */
`include "mips_bus_defs.svh"

package mips_bus_pkg;

    typedef logic [`MIPS_DATA_W-1:0]   word_t;   // data word
    typedef logic [`MIPS_DATA_W-1:0]   addr_t;   // byte address
    typedef logic [`MIPS_DATA_W/8-1:0] byteen_t; // one bit per byte lane

    // store width code from the core
    typedef logic [1:0] store_type_t;

    localparam store_type_t ST_SW   = 2'd0; // full word
    localparam store_type_t ST_SH   = 2'd1; // halfword
    localparam store_type_t ST_SB   = 2'd2; // byte
    localparam store_type_t ST_RSVD = 2'd3; // unused code behaves as sw

    // bus controller states
    typedef enum logic [2:0]
    {
        IDLE        = 3'd0, // waiting for a core request
        FETCH_INSTR = 3'd1, // instruction read on the bus
        FETCH_DATA  = 3'd2, // data read or write on the bus
        INSTR_SET   = 3'd3, // gap between data and instruction access
        HALTED      = 3'd4  // one cycle with clk_enable high
    } bus_state_t;

endpackage

/* store_lane_align.sv */
`timescale 1ns/100ps

module store_lane_align
(
    input  mips_bus_pkg::addr_t       data_address,
    input  mips_bus_pkg::word_t       data_writedata,
    input  logic                      data_write,
    input  mips_bus_pkg::store_type_t store_type,
    output mips_bus_pkg::addr_t       aligned_address,
    output mips_bus_pkg::byteen_t     lane_byteenable,
    output mips_bus_pkg::word_t       lane_writedata
);

    logic [1:0] offset;          // byte offset inside the word
    logic       misaligned_half; // sh at offset 1 or 3

    assign offset          = data_address[1:0];
    assign aligned_address = data_address & ~mips_bus_pkg::addr_t'(3); // word aligned
    assign misaligned_half = data_write && (store_type == mips_bus_pkg::ST_SH) && offset[0];

    always_comb
    begin
        // reads and sw use the whole word as it is
        lane_byteenable = '1;
        lane_writedata  = data_writedata;
        if (data_write)
        begin
            case (store_type)
                mips_bus_pkg::ST_SH:
                begin
                    if (offset[0])
                    begin
                        lane_byteenable = '0; // odd halfword, drop the store
                    end
                    else if (offset[1])
                    begin
                        lane_byteenable = 4'b1100;               // upper half
                        lane_writedata  = data_writedata << 16;
                    end
                    else
                    begin
                        lane_byteenable = 4'b0011;               // lower half, no shift
                    end
                end
                mips_bus_pkg::ST_SB:
                begin
                    // one lane, byte moved up to its offset
                    lane_byteenable = mips_bus_pkg::byteen_t'(1) << offset;
                    lane_writedata  = data_writedata << {offset, 3'b000};
                end
                mips_bus_pkg::ST_SW, mips_bus_pkg::ST_RSVD:
                begin
                    lane_byteenable = '1; // whole word
                end
            endcase
        end
    end

    // a store reaching the bus with no lanes is only legal for an odd sh
    lane_enable_check: assert final (!data_write || lane_byteenable != '0 || misaligned_half)
        else $error("store with empty byte enables, store_type %0d addr %h",
                    store_type, data_address);

endmodule

/* bus_controller.sv */
`timescale 1ns/100ps

module bus_controller
(
    input  logic                  clk,
    input  logic                  reset,

    // harvard instruction port
    input  mips_bus_pkg::addr_t   instr_address,
    input  logic                  instr_read,
    output mips_bus_pkg::word_t   instr_readdata,

    // harvard data port, address and data already lane aligned
    input  logic                  data_read,
    input  logic                  data_write,
    output mips_bus_pkg::word_t   data_readdata,
    input  mips_bus_pkg::addr_t   aligned_address,
    input  mips_bus_pkg::byteen_t lane_byteenable,
    input  mips_bus_pkg::word_t   lane_writedata,

    // core stall
    output logic                  clk_enable,

    // avalon-mm master
    output mips_bus_pkg::addr_t   av_address,
    output logic                  av_read,
    output logic                  av_write,
    output mips_bus_pkg::word_t   av_writedata,
    output mips_bus_pkg::byteen_t av_byteenable,
    input  mips_bus_pkg::word_t   av_readdata,
    input  logic                  av_waitrequest
);

    mips_bus_pkg::bus_state_t state;
    mips_bus_pkg::bus_state_t state_next;

    logic                data_req;           // exactly one of read/write
    logic                bus_done;           // access completes this cycle
    mips_bus_pkg::addr_t instr_word_address; // fetch address, word aligned

    assign data_req           = data_read ^ data_write; // both high counts as none
    assign bus_done           = (av_read | av_write) & ~av_waitrequest;
    assign instr_word_address = instr_address & ~mips_bus_pkg::addr_t'(3);

    always_comb
    begin
        state_next = state;
        case (state)
            mips_bus_pkg::IDLE:
            begin
                if (data_req)
                begin
                    state_next = mips_bus_pkg::FETCH_DATA; // data always first
                end
                else if (instr_read)
                begin
                    state_next = mips_bus_pkg::FETCH_INSTR;
                end
            end
            mips_bus_pkg::FETCH_DATA:
            begin
                if (!av_waitrequest)
                begin
                    // fetch still pending, go round through INSTR_SET
                    state_next = instr_read ? mips_bus_pkg::INSTR_SET : mips_bus_pkg::HALTED;
                end
            end
            mips_bus_pkg::INSTR_SET:
            begin
                state_next = mips_bus_pkg::FETCH_INSTR;
            end
            mips_bus_pkg::FETCH_INSTR:
            begin
                if (!av_waitrequest)
                begin
                    state_next = mips_bus_pkg::HALTED;
                end
            end
            mips_bus_pkg::HALTED:
            begin
                state_next = mips_bus_pkg::IDLE; // core steps on this edge
            end
            default:
            begin
                state_next = mips_bus_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= mips_bus_pkg::IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    // bus and stall decode
    always_comb
    begin
        clk_enable    = 1'b0; // held low in every busy state
        av_address    = '0;
        av_read       = 1'b0;
        av_write      = 1'b0;
        av_writedata  = '0;
        av_byteenable = '1;
        case (state)
            mips_bus_pkg::IDLE:
            begin
                // drop enable at once when something is asked, bus stays quiet
                clk_enable = !(data_req || instr_read);
            end
            mips_bus_pkg::FETCH_DATA:
            begin
                av_address    = aligned_address;
                av_read       = data_read;
                av_write      = data_write;
                av_writedata  = lane_writedata;
                av_byteenable = lane_byteenable;
            end
            mips_bus_pkg::FETCH_INSTR:
            begin
                av_address = instr_word_address;
                av_read    = 1'b1;
            end
            mips_bus_pkg::HALTED:
            begin
                clk_enable = 1'b1; // end of access seen by the core
            end
            default:
            begin
                clk_enable = 1'b0; // INSTR_SET, bus idle for one cycle
            end
        endcase
    end

    // read words captured on the completing edge, held until the next one
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            data_readdata  <= '0;
            instr_readdata <= '0;
        end
        else
        begin
            if (state == mips_bus_pkg::FETCH_DATA && bus_done && data_read)
            begin
                data_readdata <= av_readdata;
            end
            if (state == mips_bus_pkg::FETCH_INSTR && bus_done)
            begin
                instr_readdata <= av_readdata;
            end
        end
    end

    // read and write never share a cycle on the link
    av_cmd_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(av_read && av_write));

    // master keeps the command and address up while the slave stalls
    av_hold_on_wait: assert property (@(posedge clk) disable iff (reset)
        (av_waitrequest && (av_read || av_write))
            |=> ((av_read || av_write) && $stable(av_address)));

endmodule

/* avalon_wait_ram.sv */
`timescale 1ns/100ps
`include "mips_bus_defs.svh"

module avalon_wait_ram
(
    input  logic                  clk,
    input  logic                  reset,
    input  mips_bus_pkg::addr_t   av_address,
    input  logic                  av_read,
    input  logic                  av_write,
    input  mips_bus_pkg::word_t   av_writedata,
    input  mips_bus_pkg::byteen_t av_byteenable,
    output mips_bus_pkg::word_t   av_readdata,
    output logic                  av_waitrequest
);

    localparam int IDX_W = $clog2(`MIPS_MEM_WORDS);
    localparam int CNT_W = $clog2(`MIPS_MEM_WAIT + 2); // room for the wait value itself
    localparam int BYTES = $bits(mips_bus_pkg::byteen_t);

    mips_bus_pkg::word_t        mem [`MIPS_MEM_WORDS]; // payload, no reset
    logic [`MIPS_MEM_WORDS-1:0] valid;                 // word written since reset

    logic [IDX_W-1:0]    index;
    logic [CNT_W-1:0]    wait_count;  // cycles of the current access so far
    logic                active;
    logic                complete;
    mips_bus_pkg::word_t stored_word; // zero until first write
    mips_bus_pkg::word_t merged_word; // stored word with enabled lanes replaced

    assign index    = av_address[2 +: IDX_W]; // word index, upper bits wrap
    assign active   = av_read | av_write;
    assign complete = active & ~av_waitrequest;

    assign av_waitrequest = active && (wait_count != CNT_W'(`MIPS_MEM_WAIT));

    assign stored_word = valid[index] ? mem[index] : '0;
    assign av_readdata = stored_word; // sampled by the master on the completing cycle

    always_comb
    begin
        for (int b = 0; b < BYTES; b++)
        begin
            merged_word[8*b +: 8] = av_byteenable[b] ? av_writedata[8*b +: 8]
                                                     : stored_word[8*b +: 8];
        end
    end

    // stall counter, cleared after each completion or when the bus goes idle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wait_count <= '0;
        end
        else if (av_waitrequest)
        begin
            wait_count <= wait_count + CNT_W'(1);
        end
        else
        begin
            wait_count <= '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid <= '0; // whole memory reads zero again
        end
        else if (complete && av_write)
        begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (complete && av_write)
        begin
            mem[index] <= merged_word; // byte merge in one write
        end
    end

endmodule

/* mips_mem_subsystem.sv */
`timescale 1ns/100ps

module mips_mem_subsystem
(
    input  logic                      clk,
    input  logic                      reset,

    // instruction port
    input  mips_bus_pkg::addr_t       instr_address,
    input  logic                      instr_read,
    output mips_bus_pkg::word_t       instr_readdata,

    // data port
    input  mips_bus_pkg::addr_t       data_address,
    input  logic                      data_read,
    input  logic                      data_write,
    input  mips_bus_pkg::word_t       data_writedata,
    output mips_bus_pkg::word_t       data_readdata,
    input  mips_bus_pkg::store_type_t store_type,

    output logic                      clk_enable // core runs only when high
);

    // store formatter to controller
    mips_bus_pkg::addr_t   aligned_address;
    mips_bus_pkg::byteen_t lane_byteenable;
    mips_bus_pkg::word_t   lane_writedata;

    // avalon link, internal only
    mips_bus_pkg::addr_t   av_address;
    logic                  av_read;
    logic                  av_write;
    mips_bus_pkg::word_t   av_writedata;
    mips_bus_pkg::byteen_t av_byteenable;
    mips_bus_pkg::word_t   av_readdata;
    logic                  av_waitrequest;

    store_lane_align store_lane_align_inst
    (
        .data_address    (data_address),
        .data_writedata  (data_writedata),
        .data_write      (data_write),
        .store_type      (store_type),
        .aligned_address (aligned_address),
        .lane_byteenable (lane_byteenable),
        .lane_writedata  (lane_writedata)
    );

    bus_controller bus_controller_inst
    (
        .clk             (clk),
        .reset           (reset),
        .instr_address   (instr_address),
        .instr_read      (instr_read),
        .instr_readdata  (instr_readdata),
        .data_read       (data_read),
        .data_write      (data_write),
        .data_readdata   (data_readdata),
        .aligned_address (aligned_address),
        .lane_byteenable (lane_byteenable),
        .lane_writedata  (lane_writedata),
        .clk_enable      (clk_enable),
        .av_address      (av_address),
        .av_read         (av_read),
        .av_write        (av_write),
        .av_writedata    (av_writedata),
        .av_byteenable   (av_byteenable),
        .av_readdata     (av_readdata),
        .av_waitrequest  (av_waitrequest)
    );

    avalon_wait_ram avalon_wait_ram_inst
    (
        .clk            (clk),
        .reset          (reset),
        .av_address     (av_address),
        .av_read        (av_read),
        .av_write       (av_write),
        .av_writedata   (av_writedata),
        .av_byteenable  (av_byteenable),
        .av_readdata    (av_readdata),
        .av_waitrequest (av_waitrequest)
    );

endmodule

/* mips_mem_subsystem_tb.sv */
`timescale 1ns/100ps
`include "mips_bus_defs.svh"

module mips_mem_subsystem_tb;

    logic                      clk;
    logic                      reset;
    mips_bus_pkg::addr_t       instr_address;
    logic                      instr_read;
    mips_bus_pkg::word_t       instr_readdata;
    mips_bus_pkg::addr_t       data_address;
    logic                      data_read;
    logic                      data_write;
    mips_bus_pkg::word_t       data_writedata;
    mips_bus_pkg::word_t       data_readdata;
    mips_bus_pkg::store_type_t store_type;
    logic                      clk_enable;

    mips_bus_pkg::bus_state_t state_view; // waveform only

    mips_bus_pkg::word_t ref_mem [`MIPS_MEM_WORDS]; // reference memory
    mips_bus_pkg::word_t exp_data;                  // expected data_readdata
    mips_bus_pkg::word_t exp_instr;                 // expected instr_readdata
    logic                check_pending;             // readdata compare due
    logic                hung;                      // an access timed out

    string test_name;
    int    tests_run;
    int    checks;
    int    errors;
    int    checks_at_start;
    int    errors_at_start;

    mips_mem_subsystem mips_mem_subsystem_inst
    (
        .clk            (clk),
        .reset          (reset),
        .instr_address  (instr_address),
        .instr_read     (instr_read),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_read      (data_read),
        .data_write     (data_write),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata),
        .store_type     (store_type),
        .clk_enable     (clk_enable)
    );

    assign state_view = mips_mem_subsystem_inst.bus_controller_inst.state;

    always #20 clk = ~clk; // 40 ns period

    // ram word index wrapping at the memory depth
    function automatic int word_index(input mips_bus_pkg::addr_t a);
        return int'((a >> 2) % `MIPS_MEM_WORDS);
    endfunction

    // word after a store of the given width lands on old_word
    function automatic mips_bus_pkg::word_t merge_store(input mips_bus_pkg::word_t old_word,
                                                        input mips_bus_pkg::word_t wdata,
                                                        input mips_bus_pkg::store_type_t st,
                                                        input logic [1:0] offset);
        mips_bus_pkg::word_t result;
        result = old_word;
        case (st)
            mips_bus_pkg::ST_SH:
            begin
                if (offset == 2'd0)
                    result[15:0] = wdata[15:0];  // lower half
                else if (offset == 2'd2)
                    result[31:16] = wdata[15:0]; // upper half
                // odd offset writes nothing
            end
            mips_bus_pkg::ST_SB:
            begin
                result[8*offset +: 8] = wdata[7:0]; // low byte into lane k
            end
            default:
            begin
                result = wdata; // sw and the unused code
            end
        endcase
        return result;
    endfunction

    function automatic mips_bus_pkg::word_t expected_read(input mips_bus_pkg::addr_t a);
        return ref_mem[word_index(a)];
    endfunction

    task automatic check_word(input string what, input mips_bus_pkg::word_t expected,
                              input mips_bus_pkg::word_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("error: %s %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("error: %s %s expected %b actual %b", test_name, what, expected, actual);
        end
    endtask

    // readdata compare one cycle after the access ends
    always @(posedge clk)
    begin
        if (check_pending)
        begin
            check_word("data_readdata", exp_data, data_readdata);
            check_word("instr_readdata", exp_instr, instr_readdata);
            check_pending = 1'b0;
        end
    end

    task automatic start_test(input string name);
        test_name       = name;
        checks_at_start = checks;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        $display("%s: %s, %0d checks, %0d errors", test_name,
                 (errors == errors_at_start) ? "ok" : "failed",
                 checks - checks_at_start, errors - errors_at_start);
    endtask

    // one core request held until clk_enable comes back
    task automatic run_access(input string what, input logic rd, input logic wr,
                              input mips_bus_pkg::addr_t daddr, input mips_bus_pkg::word_t wdata,
                              input mips_bus_pkg::store_type_t st, input logic fetch,
                              input mips_bus_pkg::addr_t iaddr);
        int cycles;
        if (!hung)
        begin
            @(negedge clk);
            data_address   = daddr;
            data_writedata = wdata;
            store_type     = st;
            data_read      = rd;
            data_write     = wr;
            instr_address  = iaddr;
            instr_read     = fetch;
            // model applies data before fetch like the bus
            if (wr && !rd)
                ref_mem[word_index(daddr)] = merge_store(ref_mem[word_index(daddr)], wdata,
                                                         st, daddr[1:0]);
            if (rd && !wr)
                exp_data = expected_read(daddr);
            if (fetch)
                exp_instr = expected_read(iaddr);
            @(negedge clk);
            check_flag({what, " clk_enable while busy"}, 1'b0, clk_enable);
            cycles = 0;
            while (!clk_enable && cycles < 100)
            begin
                @(negedge clk);
                cycles++;
            end
            if (clk_enable)
            begin
                data_read     = 1'b0; // core moves on
                data_write    = 1'b0;
                instr_read    = 1'b0;
                check_pending = 1'b1;
                @(negedge clk);
                check_flag({what, " clk_enable after access"}, 1'b1, clk_enable);
            end
            else
            begin
                errors++;
                hung = 1'b1; // later requests skipped
                $display("timeout: %s access in %s hung, clk_enable low for 100 cycles",
                         what, test_name);
            end
        end
    endtask

    initial
    begin
        int                  kind;
        mips_bus_pkg::addr_t daddr;
        mips_bus_pkg::addr_t iaddr;
        mips_bus_pkg::word_t wdata;
        mips_bus_pkg::store_type_t stype;

        void'($urandom(92476));
        clk            = 1'b0;
        reset          = 1'b1;
        instr_address  = '0;
        instr_read     = 1'b0;
        data_address   = '0;
        data_read      = 1'b0;
        data_write     = 1'b0;
        data_writedata = '0;
        store_type     = mips_bus_pkg::ST_SW;
        check_pending  = 1'b0;
        hung           = 1'b0;
        exp_data       = '0;
        exp_instr      = '0;
        tests_run      = 0;
        checks         = 0;
        errors         = 0;
        for (int i = 0; i < `MIPS_MEM_WORDS; i++)
            ref_mem[i] = '0; // ram reads zero after reset
        repeat (4) @(negedge clk);
        reset = 1'b0;

        start_test("reset_values");
        @(negedge clk);
        check_flag("clk_enable", 1'b1, clk_enable);
        check_pending = 1'b1;
        @(negedge clk);
        finish_test();

        start_test("store_then_load");
        run_access("sw", 1'b0, 1'b1, 32'h100, 32'hA5A5_1234, mips_bus_pkg::ST_SW, 1'b0, '0);
        run_access("lw", 1'b1, 1'b0, 32'h100, '0, mips_bus_pkg::ST_SW, 1'b0, '0);
        finish_test();

        start_test("byte_halfword_merge");
        run_access("seed sw", 1'b0, 1'b1, 32'h40, 32'h1122_3344, mips_bus_pkg::ST_SW, 1'b0, '0);
        for (int k = 0; k < 4; k++)
        begin
            // only the low byte may land
            run_access("sb", 1'b0, 1'b1, 32'h40 + k, 32'hCAFE_BEA0 + k,
                       mips_bus_pkg::ST_SB, 1'b0, '0);
            run_access("lw after sb", 1'b1, 1'b0, 32'h40, '0, mips_bus_pkg::ST_SW, 1'b0, '0);
        end
        run_access("sh at 0", 1'b0, 1'b1, 32'h40, 32'hFFFF_5A5A, mips_bus_pkg::ST_SH, 1'b0, '0);
        run_access("lw after sh 0", 1'b1, 1'b0, 32'h40, '0, mips_bus_pkg::ST_SW, 1'b0, '0);
        run_access("sh at 2", 1'b0, 1'b1, 32'h42, 32'h0000_C3C3, mips_bus_pkg::ST_SH, 1'b0, '0);
        run_access("lw after sh 2", 1'b1, 1'b0, 32'h40, '0, mips_bus_pkg::ST_SW, 1'b0, '0);
        run_access("sh at 1", 1'b0, 1'b1, 32'h41, 32'h7777_7777, mips_bus_pkg::ST_SH, 1'b0, '0);
        run_access("lw after sh 1", 1'b1, 1'b0, 32'h40, '0, mips_bus_pkg::ST_SW, 1'b0, '0);
        finish_test();

        start_test("fetch_only");
        run_access("fetch written", 1'b0, 1'b0, '0, '0, mips_bus_pkg::ST_SW, 1'b1, 32'h40);
        run_access("fetch blank", 1'b0, 1'b0, '0, '0, mips_bus_pkg::ST_SW, 1'b1, 32'h200);
        finish_test();

        start_test("data_and_fetch");
        run_access("lw with fetch", 1'b1, 1'b0, 32'h100, '0, mips_bus_pkg::ST_SW, 1'b1, 32'h40);
        // store lands before the fetch of the same word
        run_access("sw with fetch", 1'b0, 1'b1, 32'h80, 32'h0BAD_F00D, mips_bus_pkg::ST_SW,
                   1'b1, 32'h80);
        run_access("sb with fetch", 1'b0, 1'b1, 32'h83, 32'h0000_00EE, mips_bus_pkg::ST_SB,
                   1'b1, 32'h80);
        finish_test();

        start_test("random_traffic");
        for (int n = 0; n < 200; n++)
        begin
            kind  = $urandom_range(0, 4);
            daddr = mips_bus_pkg::addr_t'($urandom_range(0, 63) * 4 + $urandom_range(0, 3));
            iaddr = mips_bus_pkg::addr_t'($urandom_range(0, 63) * 4);
            wdata = $urandom;
            stype = mips_bus_pkg::store_type_t'($urandom_range(0, 3));
            case (kind)
                0: run_access("random store", 1'b0, 1'b1, daddr, wdata, stype, 1'b0, iaddr);
                1: run_access("random load", 1'b1, 1'b0, daddr, wdata, stype, 1'b0, iaddr);
                2: run_access("random fetch", 1'b0, 1'b0, daddr, wdata, stype, 1'b1, iaddr);
                3: run_access("random load+fetch", 1'b1, 1'b0, daddr, wdata, stype, 1'b1, iaddr);
                default: run_access("random store+fetch", 1'b0, 1'b1, daddr, wdata, stype,
                                    1'b1, iaddr);
            endcase
        end
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* list.f */
+incdir+.
mips_bus_pkg.sv
store_lane_align.sv
bus_controller.sv
avalon_wait_ram.sv
mips_mem_subsystem.sv
mips_mem_subsystem_tb.sv

/* Bender.yml */
package:
  name: mips_mem_subsystem

sources:
  - include_dirs:
      - .
    files:
      - mips_bus_pkg.sv
      - store_lane_align.sv
      - bus_controller.sv
      - avalon_wait_ram.sv
      - mips_mem_subsystem.sv
      - target: test
        files:
          - mips_mem_subsystem_tb.sv
